//--- sdram_port_config.svh
`ifndef SDRAM_PORT_CONFIG_SVH
`define SDRAM_PORT_CONFIG_SVH

// **********************************************************************
// data path and SDRAM address widths
// **********************************************************************
`define SDRAM_DATA_W     16
`define SDRAM_ADDR_W     21
`define BURST_LEN_W      10

// **********************************************************************
// port FIFO sizing
// **********************************************************************
`define FIFO_AW          10    // 1024 words per FIFO

// a FIFO counts as ready once it holds this many bursts of data
`define BURST_FILL_MULT  2

`endif

//--- sdram_port_pkg.sv
`include "sdram_port_config.svh"

package sdram_port_pkg;

    typedef logic [`SDRAM_DATA_W-1:0] data_t;    // one SDRAM word
    typedef logic [`SDRAM_ADDR_W-1:0] addr_t;    // SDRAM word address
    typedef logic [`BURST_LEN_W-1:0]  len_t;     // burst length in words
    typedef logic [`FIFO_AW:0]        level_t;   // fill count with one bit over depth

    // burst scheduler states
    typedef enum logic [1:0] {
        idle,       // waiting for SDRAM init
        ready,      // picking the next FIFO
        wr_keep,    // write burst in flight
        rd_keep     // read burst in flight
    } arb_state_t;

endpackage

//--- burst_if.sv
interface burst_if;
    import sdram_port_pkg::*;

    logic  sel;      // channel of the current burst
    logic  done;     // one-cycle end of burst pulse
    addr_t addr0;    // next burst address of channel 0
    addr_t addr1;    // next burst address of channel 1

    modport arb (
        output sel,
        input  done,
        input  addr0,
        input  addr1
    );

    modport agen (
        input  sel,
        output done,
        output addr0,
        output addr1
    );

endinterface

//--- sync_fifo.sv
`include "sdram_port_config.svh"

module sync_fifo (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   clr,
    input  logic                   push,
    input  sdram_port_pkg::data_t  din,
    input  logic                   pop,
    output sdram_port_pkg::data_t  dout,
    output sdram_port_pkg::level_t level
);
    import sdram_port_pkg::*;

    localparam int unsigned DEPTH = 1 << `FIFO_AW;

    data_t               mem [DEPTH];
    logic [`FIFO_AW-1:0] wr_ptr;
    logic [`FIFO_AW-1:0] rd_ptr;
    level_t              count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && (count != level_t'(DEPTH));    // drop when full
    assign do_pop  = pop && (count != '0);                  // drop when empty

    // **********************************************************************
    // storage
    // **********************************************************************
    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // head word is always visible, so a pop takes the word shown now
    assign dout = mem[rd_ptr];

    // **********************************************************************
    // pointers and fill count
    // **********************************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            wr_ptr <= '0;    // port reset empties the FIFO
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none or both at once
            endcase
        end
    end

    assign level = count;

endmodule

//--- burst_addr_gen.sv
module burst_addr_gen (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  ack,
    input  logic                  reload,
    input  sdram_port_pkg::addr_t min_addr,
    input  sdram_port_pkg::addr_t max_addr,
    input  sdram_port_pkg::len_t  length,
    burst_if.agen                 bus
);
    import sdram_port_pkg::*;

    logic  ack_r1;
    logic  ack_r2;
    logic  reload_r1;
    logic  reload_r2;
    logic  load;
    addr_t step;
    addr_t lim0;
    addr_t lim1;

    // step one burst forward, or go back to the window start
    function automatic addr_t next_addr(addr_t cur, addr_t lim, addr_t start, addr_t inc);
        return (cur < lim) ? cur + inc : start;
    endfunction

    // **********************************************************************
    // edge detection on ack and on the port reset
    // **********************************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ack_r1    <= 1'b0;
            ack_r2    <= 1'b0;
            reload_r1 <= 1'b0;
            reload_r2 <= 1'b0;
        end else begin
            ack_r1    <= ack;
            ack_r2    <= ack_r1;
            reload_r1 <= reload;
            reload_r2 <= reload_r1;
        end
    end

    assign bus.done = ack_r2 & ~ack_r1;        // ack went low so the burst is over
    assign load     = reload_r1 & ~reload_r2;  // rising edge of port reset

    // **********************************************************************
    // address windows
    // **********************************************************************
    assign step = addr_t'(length);
    assign lim0 = max_addr - step;                    // channel 0 ends at max
    assign lim1 = addr_t'(max_addr << 1) - step;      // channel 1 ends at twice max

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bus.addr0 <= '0;
        end else if (load) begin
            bus.addr0 <= min_addr;
        end else if (bus.done && !bus.sel) begin
            bus.addr0 <= next_addr(bus.addr0, lim0, min_addr, step);
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bus.addr1 <= '0;
        end else if (load) begin
            bus.addr1 <= max_addr;    // channel 1 window starts at max
        end else if (bus.done && bus.sel) begin
            bus.addr1 <= next_addr(bus.addr1, lim1, max_addr, step);
        end
    end

endmodule

//--- channel_arbiter.sv
`include "sdram_port_config.svh"

module channel_arbiter (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   init_done,
    input  sdram_port_pkg::level_t wr_level0,
    input  sdram_port_pkg::level_t wr_level1,
    input  sdram_port_pkg::level_t rd_level0,
    input  sdram_port_pkg::level_t rd_level1,
    input  sdram_port_pkg::len_t   wr_length,
    input  sdram_port_pkg::len_t   rd_length,
    burst_if.arb                   wr_bus,
    burst_if.arb                   rd_bus,
    output logic                   wr_req,
    output sdram_port_pkg::addr_t  wr_addr,
    output logic                   rd_req,
    output sdram_port_pkg::addr_t  rd_addr
);
    import sdram_port_pkg::*;

    arb_state_t state;
    level_t     wr_thresh;
    level_t     rd_thresh;

    assign wr_thresh = level_t'(`BURST_FILL_MULT * wr_length);  // enough to drain
    assign rd_thresh = level_t'(`BURST_FILL_MULT * rd_length);  // room to refill

    // **********************************************************************
    // burst scheduler
    // fixed priority goes write 0, write 1, read 0 and then read 1
    // **********************************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= idle;
            wr_req     <= 1'b0;
            wr_addr    <= '0;
            wr_bus.sel <= 1'b0;
            rd_req     <= 1'b0;
            rd_addr    <= '0;
            rd_bus.sel <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (init_done) begin
                        state <= ready;
                    end
                end
                ready: begin
                    if (wr_level0 >= wr_thresh) begin
                        wr_req     <= 1'b1;
                        wr_addr    <= wr_bus.addr0;
                        wr_bus.sel <= 1'b0;
                        state      <= wr_keep;
                    end else if (wr_level1 >= wr_thresh) begin
                        wr_req     <= 1'b1;
                        wr_addr    <= wr_bus.addr1;
                        wr_bus.sel <= 1'b1;
                        state      <= wr_keep;
                    end else if (rd_level0 < rd_thresh) begin
                        rd_req     <= 1'b1;
                        rd_addr    <= rd_bus.addr0;
                        rd_bus.sel <= 1'b0;
                        state      <= rd_keep;
                    end else if (rd_level1 < rd_thresh) begin
                        rd_req     <= 1'b1;
                        rd_addr    <= rd_bus.addr1;
                        rd_bus.sel <= 1'b1;
                        state      <= rd_keep;
                    end
                end
                wr_keep: begin
                    if (wr_bus.done) begin    // hold request until ack falls
                        wr_req     <= 1'b0;
                        wr_bus.sel <= 1'b0;
                        state      <= ready;
                    end
                end
                rd_keep: begin
                    if (rd_bus.done) begin
                        rd_req     <= 1'b0;
                        rd_bus.sel <= 1'b0;
                        state      <= ready;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- sdram_port_ctrl.sv
module sdram_port_ctrl (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    // user write ports
    input  logic                  wr_req0,
    input  sdram_port_pkg::data_t wr_data0,
    input  logic                  wr_req1,
    input  sdram_port_pkg::data_t wr_data1,
    input  sdram_port_pkg::addr_t wr_min_addr,
    input  sdram_port_pkg::addr_t wr_max_addr,
    input  sdram_port_pkg::len_t  wr_length,
    input  logic                  wr_rst,
    // user read ports
    input  logic                  rd_req0,
    output sdram_port_pkg::data_t rd_data0,
    input  logic                  rd_req1,
    output sdram_port_pkg::data_t rd_data1,
    input  sdram_port_pkg::addr_t rd_min_addr,
    input  sdram_port_pkg::addr_t rd_max_addr,
    input  sdram_port_pkg::len_t  rd_length,
    input  logic                  rd_rst,
    // SDRAM controller side
    input  logic                  sdram_init_done,
    output logic                  sdram_wr_req,
    input  logic                  sdram_wr_ack,
    output sdram_port_pkg::addr_t sdram_wr_addr,
    output sdram_port_pkg::data_t sdram_din,
    output logic                  sdram_rd_req,
    input  logic                  sdram_rd_ack,
    output sdram_port_pkg::addr_t sdram_rd_addr,
    input  sdram_port_pkg::data_t sdram_dout
);
    import sdram_port_pkg::*;

    burst_if wr_bus ();
    burst_if rd_bus ();

    data_t  wr_head0;      // head word of write FIFO 0
    data_t  wr_head1;
    data_t  rd_din0;       // SDRAM data routed to read FIFO 0
    data_t  rd_din1;
    level_t wr_level0;
    level_t wr_level1;
    level_t rd_level0;
    level_t rd_level1;
    logic   wr_ack0;
    logic   wr_ack1;
    logic   rd_ack0;
    logic   rd_ack1;

    // **********************************************************************
    // ack steering and data muxing by the selected channel
    // **********************************************************************
    assign wr_ack0   = wr_bus.sel ? 1'b0 : sdram_wr_ack;
    assign wr_ack1   = wr_bus.sel ? sdram_wr_ack : 1'b0;
    assign rd_ack0   = rd_bus.sel ? 1'b0 : sdram_rd_ack;
    assign rd_ack1   = rd_bus.sel ? sdram_rd_ack : 1'b0;
    assign sdram_din = wr_bus.sel ? wr_head1 : wr_head0;   // valid with the ack
    assign rd_din0   = rd_bus.sel ? '0 : sdram_dout;
    assign rd_din1   = rd_bus.sel ? sdram_dout : '0;

    // **********************************************************************
    // port FIFOs
    // **********************************************************************
    sync_fifo i_wr_fifo0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .clr       (wr_rst),
        .push      (wr_req0),
        .din       (wr_data0),
        .pop       (wr_ack0),
        .dout      (wr_head0),
        .level     (wr_level0)
    );

    sync_fifo i_wr_fifo1 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .clr       (wr_rst),
        .push      (wr_req1),
        .din       (wr_data1),
        .pop       (wr_ack1),
        .dout      (wr_head1),
        .level     (wr_level1)
    );

    sync_fifo i_rd_fifo0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .clr       (rd_rst),
        .push      (rd_ack0),
        .din       (rd_din0),
        .pop       (rd_req0),
        .dout      (rd_data0),
        .level     (rd_level0)
    );

    sync_fifo i_rd_fifo1 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .clr       (rd_rst),
        .push      (rd_ack1),
        .din       (rd_din1),
        .pop       (rd_req1),
        .dout      (rd_data1),
        .level     (rd_level1)
    );

    // **********************************************************************
    // address generators, one per direction
    // **********************************************************************
    burst_addr_gen i_wr_agen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .ack       (sdram_wr_ack),
        .reload    (wr_rst),
        .min_addr  (wr_min_addr),
        .max_addr  (wr_max_addr),
        .length    (wr_length),
        .bus       (wr_bus)
    );

    burst_addr_gen i_rd_agen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .ack       (sdram_rd_ack),
        .reload    (rd_rst),
        .min_addr  (rd_min_addr),
        .max_addr  (rd_max_addr),
        .length    (rd_length),
        .bus       (rd_bus)
    );

    channel_arbiter i_arbiter (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .init_done (sdram_init_done),
        .wr_level0 (wr_level0),
        .wr_level1 (wr_level1),
        .rd_level0 (rd_level0),
        .rd_level1 (rd_level1),
        .wr_length (wr_length),
        .rd_length (rd_length),
        .wr_bus    (wr_bus),
        .rd_bus    (rd_bus),
        .wr_req    (sdram_wr_req),
        .wr_addr   (sdram_wr_addr),
        .rd_req    (sdram_rd_req),
        .rd_addr   (sdram_rd_addr)
    );

endmodule

//--- sdram_model_tb.sv
module sdram_model_tb (
    input  logic                  sys_clk,
    input  logic                  wr_req,
    input  sdram_port_pkg::addr_t wr_addr,
    input  sdram_port_pkg::data_t din,
    output logic                  wr_ack,
    input  logic                  rd_req,
    input  sdram_port_pkg::addr_t rd_addr,
    output logic                  rd_ack,
    output sdram_port_pkg::data_t dout,
    input  sdram_port_pkg::len_t  wr_length,
    input  sdram_port_pkg::len_t  rd_length
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_port_pkg::*;

    data_t mem [256];     // low 8 address bits only
    addr_t wr_log [$];    // write burst addresses in order
    addr_t rd_log [$];

    // **********************************************************************
    // serves one burst at a time with writes first
    // **********************************************************************
    initial begin : serve
        addr_t      base;
        logic [7:0] idx;
        wr_ack = 1'b0;
        rd_ack = 1'b0;
        dout   = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = data_t'(a * 257) ^ 16'hc3a5;    // pattern over the whole address
        end
        forever begin
            @(posedge sys_clk);
            if (wr_req) begin
                base = wr_addr;
                wr_log.push_back(base);
                idx = base[7:0];
                repeat (2) @(posedge sys_clk);    // command latency
                wr_ack <= 1'b1;
                for (int i = 0; i < int'(wr_length); i++) begin
                    @(posedge sys_clk);
                    mem[idx] = din;    // head word valid with the ack
                    idx = idx + 8'd1;
                    if (i == int'(wr_length) - 1) begin
                        wr_ack <= 1'b0;
                    end
                end
                while (wr_req) @(posedge sys_clk);
            end else if (rd_req) begin
                base = rd_addr;
                rd_log.push_back(base);
                idx = base[7:0];
                repeat (2) @(posedge sys_clk);
                rd_ack <= 1'b1;
                dout   <= mem[idx];
                for (int i = 0; i < int'(rd_length); i++) begin
                    @(posedge sys_clk);
                    if (i == int'(rd_length) - 1) begin
                        rd_ack <= 1'b0;
                    end else begin
                        idx = idx + 8'd1;
                        dout <= mem[idx];
                    end
                end
                while (rd_req) @(posedge sys_clk);
            end
        end
    end

endmodule

//--- tb_sdram_port_ctrl.sv
module tb_sdram_port_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_port_pkg::*;

    localparam int WIN_MIN = 0;
    localparam int WIN_MAX = 64;
    localparam int LEN     = 8;
    localparam int OP_WR   = 0;    // push words and check bursts
    localparam int OP_RB   = 1;    // push words then reload, pop and compare the reads
    localparam int OP_RST  = 2;    // write port reset drops words
    localparam int ROWS    = 8;
    localparam int LIMIT   = 300 * ROWS + 8;

    // op, port, word count, first expected burst address
    localparam int ROW_OP   [ROWS] = '{OP_WR, OP_WR, OP_WR, OP_WR, OP_WR, OP_RB, OP_RST, OP_WR};
    localparam int ROW_PORT [ROWS] = '{0, 1, 0, 0, 0, 1, 0, 0};
    localparam int ROW_CNT  [ROWS] = '{16, 16, 8, 48, 8, 8, 8, 16};
    localparam int ROW_ADDR [ROWS] = '{0, 64, 8, 16, 0, 72, -1, 0};

    logic  sys_clk, sys_rst_n;
    logic  wr_req0, wr_req1, wr_rst, rd_req0, rd_req1, rd_rst;
    data_t wr_data0, wr_data1, rd_data0, rd_data1, sdram_din, sdram_dout;
    addr_t wr_min_addr, wr_max_addr, rd_min_addr, rd_max_addr, sdram_wr_addr, sdram_rd_addr;
    len_t  wr_length, rd_length;
    logic  sdram_init_done, sdram_wr_req, sdram_wr_ack, sdram_rd_req, sdram_rd_ack;

    integer seed = 32'h3cce_2fe6;
    int     errors, checks, cycle_cnt;
    data_t  exp_q [2][$];    // words still waiting in each write FIFO
    data_t  exp_mem [int];
    int     ptr [2];
    int     exp_addrs [$];

    sdram_port_ctrl i_sdram_port_ctrl (.*);

    sdram_model_tb i_sdram_model (
        .sys_clk   (sys_clk),
        .wr_req    (sdram_wr_req),
        .wr_addr   (sdram_wr_addr),
        .din       (sdram_din),
        .wr_ack    (sdram_wr_ack),
        .rd_req    (sdram_rd_req),
        .rd_addr   (sdram_rd_addr),
        .rd_ack    (sdram_rd_ack),
        .dout      (sdram_dout),
        .wr_length (wr_length),
        .rd_length (rd_length)
    );

    always #2 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // below end minus length steps forward and otherwise goes back to start
    function automatic int advance(input int a, input int ch);
        int start;
        int lim;
        start = (ch == 1) ? WIN_MAX : WIN_MIN;
        lim   = (ch == 1) ? 2 * WIN_MAX : WIN_MAX;
        return (a < lim - LEN) ? a + LEN : start;
    endfunction

    task automatic push_words(input int port, input int n);
        data_t w;
        for (int i = 0; i < n; i++) begin
            @(posedge sys_clk);
            w = data_t'($random(seed));
            exp_q[port].push_back(w);
            if (port == 0) begin
                wr_req0  <= 1'b1;
                wr_data0 <= w;
            end else begin
                wr_req1  <= 1'b1;
                wr_data1 <= w;
            end
        end
        @(posedge sys_clk);
        wr_req0 <= 1'b0;
        wr_req1 <= 1'b0;
    endtask

    // a burst leaves once 16 words wait and takes the oldest 8
    task automatic plan_bursts(input int port);
        exp_addrs.delete();
        while (exp_q[port].size() >= 2 * LEN) begin
            for (int i = 0; i < LEN; i++) begin
                exp_mem[ptr[port] + i] = exp_q[port].pop_front();
            end
            exp_addrs.push_back(ptr[port]);
            ptr[port] = advance(ptr[port], port);
        end
    endtask

    task automatic settle_writes(input int n);
        while (i_sdram_model.wr_log.size() < n) @(posedge sys_clk);
        while (sdram_wr_req) @(posedge sys_clk);
        repeat (20) @(posedge sys_clk);    // quiet window to catch an extra burst
    endtask

    task automatic check_bursts(input int base, input int first);
        int a;
        check_val("burst count", i_sdram_model.wr_log.size(), base + exp_addrs.size());
        if (exp_addrs.size() > 0) begin
            check_val("first burst address", int'(i_sdram_model.wr_log[base]), first);
        end
        foreach (exp_addrs[k]) begin
            a = exp_addrs[k];
            check_val("sdram_wr_addr", int'(i_sdram_model.wr_log[base + k]), a);
            for (int i = 0; i < LEN; i++) begin
                check_val("memory word", int'(i_sdram_model.mem[a + i]), int'(exp_mem[a + i]));
            end
        end
    endtask

    task automatic pop_check(input int port, input int start);
        @(posedge sys_clk);
        if (port == 0) rd_req0 <= 1'b1;
        else rd_req1 <= 1'b1;
        for (int i = 0; i < 2 * LEN; i++) begin
            @(posedge sys_clk);    // word popped at this edge
            if (port == 0) check_val("rd_data0", int'(rd_data0), int'(exp_mem[start + i]));
            else check_val("rd_data1", int'(rd_data1), int'(exp_mem[start + i]));
            if (i == 2 * LEN - 1) begin
                rd_req0 <= 1'b0;
                rd_req1 <= 1'b0;
            end
        end
    endtask

    task automatic pulse_wr_rst();
        @(posedge sys_clk);
        wr_rst <= 1'b1;
        @(posedge sys_clk);
        wr_rst <= 1'b0;
        repeat (4) @(posedge sys_clk);    // load lands 2 cycles after the edge
        exp_q[0].delete();
        exp_q[1].delete();
        ptr[0] = WIN_MIN;
        ptr[1] = WIN_MAX;
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin
        int base, rd_base, err_before;
        sys_clk = 0;
        sys_rst_n = 0;
        cycle_cnt = 0;
        errors = 0;
        checks = 0;
        wr_req0 = 0;
        wr_req1 = 0;
        wr_data0 = '0;
        wr_data1 = '0;
        wr_rst = 0;
        rd_req0 = 0;
        rd_req1 = 0;
        rd_rst = 0;
        sdram_init_done = 0;
        wr_min_addr = addr_t'(WIN_MIN);
        wr_max_addr = addr_t'(WIN_MAX);
        rd_min_addr = addr_t'(WIN_MIN);
        rd_max_addr = addr_t'(WIN_MAX);
        wr_length = len_t'(LEN);
        rd_length = len_t'(LEN);
        ptr[0] = WIN_MIN;
        ptr[1] = WIN_MAX;

        // no request may leave before init
        repeat (8) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(posedge sys_clk);
        wr_rst <= 1'b1;
        rd_rst <= 1'b1;
        @(posedge sys_clk);
        wr_rst <= 1'b0;
        rd_rst <= 1'b0;
        repeat (6) begin
            @(posedge sys_clk);
            check_val("sdram_wr_req", int'(sdram_wr_req), 0);
            check_val("sdram_rd_req", int'(sdram_rd_req), 0);
        end
        sdram_init_done <= 1'b1;
        $display("test init: %s", (errors == 0) ? "ok" : "failed");

        for (int r = 0; r < ROWS; r++) begin
            err_before = errors;
            base = i_sdram_model.wr_log.size();
            if (ROW_OP[r] == OP_RST) begin
                pulse_wr_rst();
                push_words(ROW_PORT[r], ROW_CNT[r]);
                repeat (30) @(posedge sys_clk);
                check_val("burst count", i_sdram_model.wr_log.size(), base);
                pulse_wr_rst();
            end else begin
                push_words(ROW_PORT[r], ROW_CNT[r]);
                plan_bursts(ROW_PORT[r]);
                if (ROW_OP[r] == OP_RB) begin
                    while (!sdram_wr_req) @(posedge sys_clk);
                    rd_base = i_sdram_model.rd_log.size();
                    @(posedge sys_clk);
                    rd_rst <= 1'b1;
                    @(posedge sys_clk);
                    rd_rst <= 1'b0;
                end
                settle_writes(base + exp_addrs.size());
                check_bursts(base, ROW_ADDR[r]);
                if (ROW_OP[r] == OP_RB) begin
                    while (i_sdram_model.rd_log.size() < rd_base + 4) @(posedge sys_clk);
                    while (sdram_rd_req) @(posedge sys_clk);
                    check_val("sdram_rd_addr", int'(i_sdram_model.rd_log[rd_base]), 0);
                    check_val("sdram_rd_addr", int'(i_sdram_model.rd_log[rd_base + 1]), 8);
                    check_val("sdram_rd_addr", int'(i_sdram_model.rd_log[rd_base + 2]), 64);
                    check_val("sdram_rd_addr", int'(i_sdram_model.rd_log[rd_base + 3]), 72);
                    pop_check(0, WIN_MIN);
                    pop_check(1, WIN_MAX);
                end
            end
            $display("test %0d port %0d: %s", r, ROW_PORT[r],
                     (errors == err_before) ? "ok" : "failed");
        end

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
sdram_port_pkg.sv
burst_if.sv
sync_fifo.sv
burst_addr_gen.sv
channel_arbiter.sv
sdram_port_ctrl.sv
sdram_model_tb.sv
tb_sdram_port_ctrl.sv

//--- Makefile
TOP := tb_sdram_port_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module sdram_port_ctrl
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f *.sv *.svh
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
